/* source/dbg_pkg.sv */
package dbg_pkg;

    ////////////////////
    // timing and sizes
    ////////////////////

    // about 115200 baud at 10 MHz
    localparam int unsigned CLKS_PER_BIT = 87;

    // partial word is dropped after this long without a new start bit
    localparam int unsigned BYTE_GAP_CLKS = 20 * CLKS_PER_BIT;

    // per argument word of a multi-word exchange
    localparam int unsigned WAIT_TIMEOUT_CLKS = 50000;

    localparam int unsigned MAX_HW_BREAKPOINTS = 8;
    localparam int unsigned HB_IDX_WIDTH = $clog2(MAX_HW_BREAKPOINTS);

    ////////////////////
    // types
    ////////////////////

    typedef logic [31:0] word_t;

    // memory request seen by the core, sync read
    typedef struct packed {
        word_t addr;
        word_t din;
        logic  en;
        logic  we;
    } mem_req_t;

    // breakpoint slot update
    typedef struct packed {
        logic [HB_IDX_WIDTH-1:0] idx;
        word_t                   addr;
        logic                    set;
        logic                    clr;
    } hb_cmd_t;

    ////////////////////
    // protocol
    ////////////////////

    // sent for a multi-word timeout
    localparam word_t FAIL_RESPONSE = 32'hF00FF00F;

    // command codes, upper three bytes of the command word
    localparam logic [23:0] CMD_RESET_ON     = 24'h0FF000;
    localparam logic [23:0] CMD_RESET_OFF    = 24'h0FF001;
    localparam logic [23:0] CMD_PAUSE        = 24'h0FF005;
    localparam logic [23:0] CMD_STEP         = 24'h0FF006;
    localparam logic [23:0] CMD_CONTINUE     = 24'h0FF007;
    localparam logic [23:0] CMD_STATUS       = 24'h0FF008;
    localparam logic [23:0] CMD_READ_MEM     = 24'h0FF009;
    localparam logic [23:0] CMD_WRITE_MEM    = 24'h0FF00A;
    localparam logic [23:0] CMD_SET_HW_BREAK = 24'h0FF00D;
    localparam logic [23:0] CMD_CLR_HW_BREAK = 24'h0FF00E;

endpackage

/* source/uart_rx_word.sv */
`timescale 1ns/1ps

module uart_rx_word (
    input  logic          clk,
    input  logic          clr_mcu_reset,
    input  logic          srx,
    output logic          rx_ready,
    output dbg_pkg::word_t rx_word
);
    import dbg_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t state;
    logic srx_meta;
    logic srx_sync;
    logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
    logic [$clog2(BYTE_GAP_CLKS)-1:0] gap_cnt;
    logic [2:0] bit_cnt;
    logic [1:0] byte_cnt;
    logic [7:0] byte_sr;
    logic [23:0] word_sr;

    // two-flop synchronizer on the serial line
    always_ff @(posedge clk) begin
        if (clr_mcu_reset) begin
            srx_meta <= 1'b1;
            srx_sync <= 1'b1;
        end else begin
            srx_meta <= srx;
            srx_sync <= srx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (clr_mcu_reset) begin
            state <= RX_IDLE;
            clk_cnt <= '0;
            gap_cnt <= '0;
            bit_cnt <= '0;
            byte_cnt <= '0;
            rx_ready <= 1'b0;
        end else begin
            rx_ready <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (!srx_sync) begin
                        gap_cnt <= '0;
                        state <= RX_START;
                    end else if (byte_cnt != 2'd0) begin
                        // drop a partial word after a long gap
                        if (gap_cnt == BYTE_GAP_CLKS - 1) begin
                            byte_cnt <= '0;
                            gap_cnt <= '0;
                        end else begin
                            gap_cnt <= gap_cnt + 1'b1;
                        end
                    end
                end
                RX_START: begin
                    // recheck the start bit at its centre
                    if (clk_cnt == CLKS_PER_BIT / 2) begin
                        clk_cnt <= '0;
                        state <= srx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CLKS_PER_BIT - 1) begin
                        clk_cnt <= '0;
                        // lsb first
                        byte_sr <= {srx_sync, byte_sr[7:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == CLKS_PER_BIT - 1) begin
                        clk_cnt <= '0;
                        state <= RX_IDLE;
                        if (srx_sync) begin
                            word_sr <= {word_sr[15:0], byte_sr};
                            byte_cnt <= byte_cnt + 1'b1;
                            if (byte_cnt == 2'd3) begin
                                rx_word <= {word_sr, byte_sr};
                                rx_ready <= 1'b1;
                            end
                        end else begin
                            // framing error, lose the partial word
                            byte_cnt <= '0;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // a word takes 40 bit times, so ready can never repeat back to back
    a_ready_single: assert property (
        @(posedge clk) disable iff (clr_mcu_reset) rx_ready |=> !rx_ready
    );

endmodule

/* source/uart_tx_word.sv */
`timescale 1ns/1ps

module uart_tx_word (
    input  logic           clk,
    input  logic           clr_mcu_reset,
    input  logic           start,
    input  dbg_pkg::word_t tx_word,
    output logic           stx,
    output logic           tx_idle
);
    import dbg_pkg::*;

    logic busy;
    logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
    logic [3:0] bit_cnt;
    logic [1:0] byte_cnt;
    // data bits and stop bit still to go out for the current byte
    logic [8:0] frame;
    logic [23:0] rest;

    assign tx_idle = !busy;

    always_ff @(posedge clk) begin
        if (clr_mcu_reset) begin
            busy <= 1'b0;
            stx <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            byte_cnt <= '0;
        end else if (!busy) begin
            if (start) begin
                // msb first, start bit goes out right away
                busy <= 1'b1;
                stx <= 1'b0;
                frame <= {1'b1, tx_word[31:24]};
                rest <= tx_word[23:0];
                clk_cnt <= '0;
                bit_cnt <= '0;
                byte_cnt <= '0;
            end
        end else if (clk_cnt == CLKS_PER_BIT - 1) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                // stop bit finished
                bit_cnt <= '0;
                if (byte_cnt == 2'd3) begin
                    busy <= 1'b0;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                    stx <= 1'b0;
                    frame <= {1'b1, rest[23:16]};
                    rest <= {rest[15:0], 8'h00};
                end
            end else begin
                stx <= frame[0];
                frame <= {1'b1, frame[8:1]};
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (clr_mcu_reset) start |-> tx_idle
    );

endmodule

/* source/hw_breakpoints.sv */
`timescale 1ns/1ps

module hw_breakpoints (
    input  logic             clk,
    input  logic             clr_mcu_reset,
    input  dbg_pkg::hb_cmd_t hb_cmd,
    input  dbg_pkg::word_t   pc_next,
    input  logic             cu_pausable,
    output logic             hb_pause
);
    import dbg_pkg::*;

    word_t bp_addr [MAX_HW_BREAKPOINTS];
    logic [MAX_HW_BREAKPOINTS-1:0] bp_valid;

    always_ff @(posedge clk) begin
        if (clr_mcu_reset) begin
            bp_valid <= '0;
        end else if (hb_cmd.set) begin
            bp_valid[hb_cmd.idx] <= 1'b1;
        end else if (hb_cmd.clr) begin
            bp_valid[hb_cmd.idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hb_cmd.set) begin
            bp_addr[hb_cmd.idx] <= hb_cmd.addr;
        end
    end

    // match is combinational so the core stops before the matching fetch
    always_comb begin
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < MAX_HW_BREAKPOINTS; i++) begin
            hit |= bp_valid[i] && (bp_addr[i] == pc_next);
        end
        hb_pause = cu_pausable && hit;
    end

    a_set_clr_excl: assert property (
        @(posedge clk) disable iff (clr_mcu_reset) !(hb_cmd.set && hb_cmd.clr)
    );

endmodule

/* source/dbg_cmd_fsm.sv */
`timescale 1ns/1ps

module dbg_cmd_fsm (
    input  logic              clk,
    input  logic              clr_mcu_reset,
    input  logic              rx_ready,
    input  dbg_pkg::word_t    rx_word,
    input  logic              tx_idle,
    output logic              tx_send,
    output dbg_pkg::word_t    tx_word,
    output dbg_pkg::mem_req_t mem_req,
    input  dbg_pkg::word_t    mem_dout,
    output dbg_pkg::hb_cmd_t  hb_cmd,
    input  logic              hb_pause,
    input  logic              cu_paused,
    output logic              cu_pause,
    output logic              mcu_reset
);
    import dbg_pkg::*;

    typedef enum logic [3:0] {
        IDLE, FAILED, WAIT_PAUSED, S_PAUSE, ST_SEND_STATUS,
        RM_WAIT_ADDR, RM_READ_DATA, RM_SEND_DATA,
        WM_WAIT_ADDR, WM_WAIT_DATA,
        SHB_WAIT_INDEX, SHB_WAIT_ADDR,
        CHB_WAIT_INDEX, CHB_CLEAR,
        SEND_CKSUM
    } state_t;

    typedef enum logic [2:0] {SEL_ECHO, SEL_MEMD, SEL_STATUS, SEL_CKSUM, SEL_FAIL} tx_sel_t;

    state_t state;
    state_t next_state;
    tx_sel_t tx_sel;

    word_t r_addr;
    word_t r_cksum;
    logic [HB_IDX_WIDTH-1:0] r_idx;
    logic r_mcu_reset;
    logic r_cu_pause;
    logic [$clog2(WAIT_TIMEOUT_CLKS+1)-1:0] wait_cnt;

    logic rx_valid;
    logic waiting;
    logic timed_out;
    logic set_reset, clr_reset;
    logic set_pause, clr_pause;
    logic ld_addr, ld_idx;
    logic clr_cksum, acc_rx, acc_tx;

    // command bytes must xor to zero
    assign rx_valid = (rx_word[7:0] ^ rx_word[15:8] ^ rx_word[23:16] ^ rx_word[31:24]) == 8'h00;
    assign timed_out = (wait_cnt == WAIT_TIMEOUT_CLKS);
    assign waiting = state inside {RM_WAIT_ADDR, WM_WAIT_ADDR, WM_WAIT_DATA,
                                   SHB_WAIT_INDEX, SHB_WAIT_ADDR, CHB_WAIT_INDEX};

    assign mcu_reset = clr_mcu_reset || r_mcu_reset;
    assign cu_pause = r_cu_pause || hb_pause;

    ////////////////////
    // response word
    ////////////////////

    always_comb begin
        case (tx_sel)
            SEL_ECHO:   tx_word = rx_word;
            SEL_MEMD:   tx_word = mem_dout;
            SEL_STATUS: tx_word = {30'b0, cu_pause, mcu_reset};
            SEL_CKSUM:  tx_word = r_cksum;
            default:    tx_word = FAIL_RESPONSE;
        endcase
    end

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        next_state = state;
        tx_send = 1'b0;
        tx_sel = SEL_ECHO;
        mem_req = '{addr: r_addr, din: rx_word, en: 1'b0, we: 1'b0};
        hb_cmd = '{idx: r_idx, addr: rx_word, set: 1'b0, clr: 1'b0};
        {set_reset, clr_reset, set_pause, clr_pause} = '0;
        {ld_addr, ld_idx, clr_cksum, acc_rx, acc_tx} = '0;

        case (state)
            IDLE: begin
                if (rx_ready && rx_valid && tx_idle) begin
                    case (rx_word[31:8])
                        CMD_RESET_ON:  begin set_reset = 1'b1; tx_send = 1'b1; end
                        CMD_RESET_OFF: begin clr_reset = 1'b1; tx_send = 1'b1; end
                        CMD_CONTINUE:  begin clr_pause = 1'b1; tx_send = 1'b1; end
                        // pause echoes only once the core has stopped
                        CMD_PAUSE: begin
                            set_pause = 1'b1;
                            next_state = WAIT_PAUSED;
                        end
                        // one cycle without pause lets one instruction through
                        CMD_STEP: begin
                            clr_pause = 1'b1;
                            next_state = S_PAUSE;
                        end
                        CMD_STATUS, CMD_READ_MEM, CMD_WRITE_MEM,
                        CMD_SET_HW_BREAK, CMD_CLR_HW_BREAK: begin
                            tx_send = 1'b1;
                            clr_cksum = 1'b1;
                            case (rx_word[31:8])
                                CMD_STATUS:       next_state = ST_SEND_STATUS;
                                CMD_READ_MEM:     next_state = RM_WAIT_ADDR;
                                CMD_WRITE_MEM:    next_state = WM_WAIT_ADDR;
                                CMD_SET_HW_BREAK: next_state = SHB_WAIT_INDEX;
                                default:          next_state = CHB_WAIT_INDEX;
                            endcase
                        end
                        default: ;
                    endcase
                end
            end
            FAILED: begin
                if (tx_idle) begin
                    tx_sel = SEL_FAIL;
                    tx_send = 1'b1;
                    next_state = IDLE;
                end
            end
            S_PAUSE: begin
                set_pause = 1'b1;
                next_state = WAIT_PAUSED;
            end
            WAIT_PAUSED: begin
                // a core in reset counts as paused
                if (cu_paused || mcu_reset) begin
                    tx_send = 1'b1;
                    next_state = IDLE;
                end
            end
            ST_SEND_STATUS: begin
                if (tx_idle) begin
                    tx_sel = SEL_STATUS;
                    tx_send = 1'b1;
                    acc_tx = 1'b1;
                    next_state = SEND_CKSUM;
                end
            end
            RM_WAIT_ADDR, WM_WAIT_ADDR: begin
                if (timed_out) begin
                    next_state = FAILED;
                end else if (rx_ready) begin
                    ld_addr = 1'b1;
                    acc_rx = 1'b1;
                    next_state = (state == RM_WAIT_ADDR) ? RM_READ_DATA : WM_WAIT_DATA;
                end
            end
            RM_READ_DATA: begin
                // read data lasts one cycle, so the transmitter must be free first
                if (tx_idle) begin
                    mem_req.en = 1'b1;
                    next_state = RM_SEND_DATA;
                end
            end
            RM_SEND_DATA: begin
                tx_sel = SEL_MEMD;
                tx_send = 1'b1;
                acc_tx = 1'b1;
                next_state = SEND_CKSUM;
            end
            WM_WAIT_DATA: begin
                if (timed_out) begin
                    next_state = FAILED;
                end else if (rx_ready) begin
                    mem_req.en = 1'b1;
                    mem_req.we = 1'b1;
                    acc_rx = 1'b1;
                    next_state = SEND_CKSUM;
                end
            end
            SHB_WAIT_INDEX, CHB_WAIT_INDEX: begin
                if (timed_out) begin
                    next_state = FAILED;
                end else if (rx_ready) begin
                    ld_idx = 1'b1;
                    acc_rx = 1'b1;
                    next_state = (state == SHB_WAIT_INDEX) ? SHB_WAIT_ADDR : CHB_CLEAR;
                end
            end
            SHB_WAIT_ADDR: begin
                if (timed_out) begin
                    next_state = FAILED;
                end else if (rx_ready) begin
                    hb_cmd.set = 1'b1;
                    acc_rx = 1'b1;
                    next_state = SEND_CKSUM;
                end
            end
            CHB_CLEAR: begin
                hb_cmd.clr = 1'b1;
                next_state = SEND_CKSUM;
            end
            SEND_CKSUM: begin
                if (tx_idle) begin
                    tx_sel = SEL_CKSUM;
                    tx_send = 1'b1;
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (clr_mcu_reset) begin
            state <= IDLE;
            r_mcu_reset <= 1'b0;
            r_cu_pause <= 1'b0;
            wait_cnt <= '0;
        end else begin
            state <= next_state;
            if (set_reset) begin
                r_mcu_reset <= 1'b1;
            end else if (clr_reset) begin
                r_mcu_reset <= 1'b0;
            end
            // a breakpoint hit holds the pause
            if (set_pause || hb_pause) begin
                r_cu_pause <= 1'b1;
            end else if (clr_pause) begin
                r_cu_pause <= 1'b0;
            end
            // restarts for every argument word
            if (waiting && !rx_ready) begin
                if (!timed_out) begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end else begin
                wait_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_addr) begin
            r_addr <= rx_word;
        end
        if (ld_idx) begin
            r_idx <= rx_word[HB_IDX_WIDTH-1:0];
        end
        if (clr_cksum) begin
            r_cksum <= '0;
        end else if (acc_rx) begin
            r_cksum <= r_cksum ^ rx_word;
        end else if (acc_tx) begin
            r_cksum <= r_cksum ^ tx_word;
        end
    end

    a_send_idle: assert property (
        @(posedge clk) disable iff (clr_mcu_reset) tx_send |-> tx_idle
    );
    a_we_en: assert property (
        @(posedge clk) disable iff (clr_mcu_reset) mem_req.we |-> mem_req.en
    );

endmodule

/* source/dbg_top.sv */
`timescale 1ns/1ps

module dbg_top (
    input  logic              clk,
    input  logic              clr_mcu_reset,
    input  logic              srx,
    output logic              stx,
    output logic              mcu_reset,
    output logic              cu_pause,
    input  logic              cu_pausable,
    input  logic              cu_paused,
    output dbg_pkg::mem_req_t mem_req,
    input  dbg_pkg::word_t    mem_dout,
    input  dbg_pkg::word_t    pc_next
);
    import dbg_pkg::*;

    logic    rx_ready;
    word_t   rx_word;
    logic    tx_send;
    word_t   tx_word;
    logic    tx_idle;
    hb_cmd_t hb_cmd;
    logic    hb_pause;

    uart_rx_word u_uart_rx (
        .clk           (clk),
        .clr_mcu_reset (clr_mcu_reset),
        .srx           (srx),
        .rx_ready      (rx_ready),
        .rx_word       (rx_word)
    );

    uart_tx_word u_uart_tx (
        .clk           (clk),
        .clr_mcu_reset (clr_mcu_reset),
        .start         (tx_send),
        .tx_word       (tx_word),
        .stx           (stx),
        .tx_idle       (tx_idle)
    );

    dbg_cmd_fsm u_cmd_fsm (
        .clk           (clk),
        .clr_mcu_reset (clr_mcu_reset),
        .rx_ready      (rx_ready),
        .rx_word       (rx_word),
        .tx_idle       (tx_idle),
        .tx_send       (tx_send),
        .tx_word       (tx_word),
        .mem_req       (mem_req),
        .mem_dout      (mem_dout),
        .hb_cmd        (hb_cmd),
        .hb_pause      (hb_pause),
        .cu_paused     (cu_paused),
        .cu_pause      (cu_pause),
        .mcu_reset     (mcu_reset)
    );

    hw_breakpoints u_hw_bp (
        .clk           (clk),
        .clr_mcu_reset (clr_mcu_reset),
        .hb_cmd        (hb_cmd),
        .pc_next       (pc_next),
        .cu_pausable   (cu_pausable),
        .hb_pause      (hb_pause)
    );

endmodule

/* testbench/dbg_tb.sv */
`timescale 1ns/1ps

module dbg_tb;
    import dbg_pkg::*;

    localparam int unsigned WORD_CLKS = 40 * CLKS_PER_BIT;
    localparam int unsigned REPLY_CLKS = 4 * WORD_CLKS;
    localparam int unsigned RUN_LIMIT_CLKS = 600000;

    logic     clk = 1'b0;
    logic     clr_mcu_reset;
    logic     srx;
    logic     stx;
    logic     mcu_reset;
    logic     cu_pause;
    logic     cu_pausable;
    logic     cu_paused = 1'b0;
    mem_req_t mem_req;
    word_t    mem_dout = '0;
    word_t    pc_next;

    word_t mem [256];
    logic  pause_d;

    // host receiver state
    word_t      rx_q [$];
    int         mon_cnt;
    logic       mon_busy;
    logic [7:0] mon_byte;
    word_t      mon_word;
    int         mon_bytes;

    int    errors;
    int    checks;
    string test_name;

    dbg_top dut (
        .clk           (clk),
        .clr_mcu_reset (clr_mcu_reset),
        .srx           (srx),
        .stx           (stx),
        .mcu_reset     (mcu_reset),
        .cu_pause      (cu_pause),
        .cu_pausable   (cu_pausable),
        .cu_paused     (cu_paused),
        .mem_req       (mem_req),
        .mem_dout      (mem_dout),
        .pc_next       (pc_next)
    );

    initial begin
        forever begin
            #50;
            clk = ~clk;
        end
    end

    ////////////////////
    // core side models
    ////////////////////

    // sync read memory of 256 words aliased over the address space
    always @(posedge clk) begin
        if (mem_req.en) begin
            if (mem_req.we) begin
                mem[mem_req.addr[7:0]] = mem_req.din;
            end else begin
                mem_dout <= mem[mem_req.addr[7:0]];
            end
        end
    end

    // control unit stops two cycles after the pause request
    always @(posedge clk) begin
        if (clr_mcu_reset) begin
            pause_d <= 1'b0;
            cu_paused <= 1'b0;
        end else begin
            pause_d <= cu_pause;
            cu_paused <= pause_d && cu_pause;
        end
    end

    // host receiver samples stx on the falling edge
    always @(negedge clk) begin
        if (clr_mcu_reset !== 1'b0) begin
            mon_busy = 1'b0;
            mon_bytes = 0;
        end else if (!mon_busy) begin
            if (stx === 1'b0) begin
                mon_busy = 1'b1;
                mon_cnt = 0;
            end
        end else begin
            mon_cnt = mon_cnt + 1;
            if (mon_cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                if (mon_cnt / CLKS_PER_BIT == 0) begin
                    // a glitch is not a start bit
                    if (stx !== 1'b0) begin
                        mon_busy = 1'b0;
                    end
                end else if (mon_cnt / CLKS_PER_BIT <= 8) begin
                    mon_byte = {stx, mon_byte[7:1]};
                end else begin
                    if (stx !== 1'b1) begin
                        $display("framing error on stx during test %s", test_name);
                        errors++;
                    end
                    mon_word = {mon_word[23:0], mon_byte};
                    mon_bytes++;
                    if (mon_bytes == 4) begin
                        rx_q.push_back(mon_word);
                        mon_bytes = 0;
                    end
                    mon_busy = 1'b0;
                end
            end
        end
    end

    ////////////////////
    // host tasks
    ////////////////////

    function automatic word_t cmd_word(input logic [23:0] code);
        // low byte makes the four bytes xor to zero
        return {code, code[23:16] ^ code[15:8] ^ code[7:0]};
    endfunction

    function automatic word_t status_word(input logic pause, input logic rst);
        return {30'b0, pause, rst};
    endfunction

    task automatic check(input string what, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s, %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // msb byte first and each byte lsb first between start and stop bits
    task automatic send_word(input word_t w);
        logic [9:0] frame;
        for (int b = 3; b >= 0; b--) begin
            frame = {1'b1, w[8*b +: 8], 1'b0};
            for (int i = 0; i < 10; i++) begin
                @(posedge clk);
                srx <= frame[i];
                repeat (CLKS_PER_BIT - 1) @(posedge clk);
            end
        end
    endtask

    task automatic get_word(input int unsigned limit, output word_t w, output bit ok);
        int unsigned n;
        n = 0;
        while (rx_q.size() == 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        ok = (rx_q.size() != 0);
        w = ok ? rx_q.pop_front() : 'x;
        if (!ok) begin
            $display("no reply on stx within %0d cycles in test %s", limit, test_name);
            errors++;
        end
    endtask

    task automatic expect_word(input string what, input word_t exp, input int unsigned limit);
        word_t w;
        bit    ok;
        get_word(limit, w, ok);
        if (ok) begin
            check(what, exp, w);
        end
    endtask

    task automatic query_status(input logic pause, input logic rst);
        send_word(cmd_word(CMD_STATUS));
        expect_word("status echo", cmd_word(CMD_STATUS), REPLY_CLKS);
        expect_word("status word", status_word(pause, rst), REPLY_CLKS);
        expect_word("status checksum", status_word(pause, rst), REPLY_CLKS);
    endtask

    task automatic simple_cmd(input string what, input logic [23:0] code);
        send_word(cmd_word(code));
        expect_word(what, cmd_word(code), REPLY_CLKS);
        @(negedge clk);
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic reset_and_status();
        test_name = "reset_status";
        simple_cmd("reset on echo", CMD_RESET_ON);
        check("mcu_reset held", 1, mcu_reset);
        query_status(1'b0, 1'b1);
        simple_cmd("reset off echo", CMD_RESET_OFF);
        check("mcu_reset released", 0, mcu_reset);
        query_status(1'b0, 1'b0);
    endtask

    task automatic mem_write_read();
        word_t addr;
        word_t data;
        test_name = "mem_write_read";
        addr = $urandom;
        data = $urandom;
        send_word(cmd_word(CMD_WRITE_MEM));
        send_word(addr);
        send_word(data);
        expect_word("write echo", cmd_word(CMD_WRITE_MEM), REPLY_CLKS);
        expect_word("write checksum", addr ^ data, REPLY_CLKS);
        check("model memory", data, mem[addr[7:0]]);
        send_word(cmd_word(CMD_READ_MEM));
        send_word(addr);
        expect_word("read echo", cmd_word(CMD_READ_MEM), REPLY_CLKS);
        expect_word("read data", data, REPLY_CLKS);
        expect_word("read checksum", addr ^ data, REPLY_CLKS);
    endtask

    task automatic pause_continue_step();
        test_name = "pause_step";
        simple_cmd("pause echo", CMD_PAUSE);
        check("cu_pause after pause", 1, cu_pause);
        query_status(1'b1, 1'b0);
        simple_cmd("continue echo", CMD_CONTINUE);
        check("cu_pause after continue", 0, cu_pause);
        query_status(1'b0, 1'b0);
        simple_cmd("step echo", CMD_STEP);
        check("cu_pause after step", 1, cu_pause);
        query_status(1'b1, 1'b0);
        simple_cmd("continue echo", CMD_CONTINUE);
    endtask

    task automatic breakpoint_hit_clear();
        word_t bp;
        test_name = "hw_breakpoints";
        bp = $urandom;
        send_word(cmd_word(CMD_SET_HW_BREAK));
        send_word(32'd3);
        send_word(bp);
        expect_word("set echo", cmd_word(CMD_SET_HW_BREAK), REPLY_CLKS);
        expect_word("set checksum", 32'd3 ^ bp, REPLY_CLKS);
        @(posedge clk);
        pc_next <= bp;
        cu_pausable <= 1'b1;
        repeat (2) @(negedge clk);
        check("cu_pause on hit", 1, cu_pause);
        query_status(1'b1, 1'b0);
        send_word(cmd_word(CMD_CLR_HW_BREAK));
        send_word(32'd3);
        expect_word("clear echo", cmd_word(CMD_CLR_HW_BREAK), REPLY_CLKS);
        expect_word("clear checksum", 32'd3, REPLY_CLKS);
        simple_cmd("continue echo", CMD_CONTINUE);
        repeat (2) @(negedge clk);
        check("cu_pause after clear", 0, cu_pause);
        query_status(1'b0, 1'b0);
        @(posedge clk);
        cu_pausable <= 1'b0;
        pc_next <= '0;
    endtask

    task automatic timeout_and_reject();
        word_t bad;
        test_name = "timeout_reject";
        send_word(cmd_word(CMD_READ_MEM));
        expect_word("read echo", cmd_word(CMD_READ_MEM), REPLY_CLKS);
        expect_word("fail word", FAIL_RESPONSE, WAIT_TIMEOUT_CLKS + 2 * WORD_CLKS);
        // flipping one bit breaks the byte xor
        bad = cmd_word(CMD_STATUS) ^ 32'h0000_0001;
        send_word(bad);
        repeat (3 * WORD_CLKS) @(posedge clk);
        check("words after bad command", 0, rx_q.size());
        query_status(1'b0, 1'b0);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        word_t seed_val;
        errors = 0;
        checks = 0;
        test_name = "init";
        seed_val = $urandom(32'hfb4507c7);
        for (int i = 0; i < 256; i++) begin
            mem[i] = {4{i[7:0]}} ^ 32'h3c5a_96e1;
        end
        clr_mcu_reset <= 1'b1;
        srx <= 1'b1;
        cu_pausable <= 1'b0;
        pc_next <= '0;
        repeat (2) @(posedge clk);
        clr_mcu_reset <= 1'b0;
        @(posedge clk);

        reset_and_status();
        mem_write_read();
        pause_continue_step();
        breakpoint_hit_clear();
        timeout_and_reject();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // run limit
    initial begin
        for (int unsigned n = 0; n < RUN_LIMIT_CLKS; n++) begin
            @(posedge clk);
        end
        $display("run did not finish within %0d cycles", RUN_LIMIT_CLKS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* dbg_top.f */
source/dbg_pkg.sv
source/uart_rx_word.sv
source/uart_tx_word.sv
source/hw_breakpoints.sv
source/dbg_cmd_fsm.sv
source/dbg_top.sv
testbench/dbg_tb.sv
